// File: icache_pkg.sv
`default_nettype none

package icache_pkg;

  ////////////////////////////////////////
  // Address geometry
  ////////////////////////////////////////

  localparam int unsigned PhysAddrLen     = 32;
  localparam int unsigned LineOffsetWidth = 6;
  localparam int unsigned WordsPerLine    = 16;
  localparam int unsigned WordOffsetWidth = $clog2(WordsPerLine);
  // Byte bits below the word offset
  localparam int unsigned ByteOffsetWidth = LineOffsetWidth - WordOffsetWidth;
  localparam int unsigned SetsWidth       = 6;
  localparam int unsigned NumSets         = 2 ** SetsWidth;
  localparam int unsigned TagWidth        = PhysAddrLen - SetsWidth - LineOffsetWidth;

  ////////////////////////////////////////
  // Cache types
  ////////////////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [SetsWidth-1:0] set_t;

  // Set index in the upper bits, word offset in the lower bits
  typedef logic [SetsWidth+WordOffsetWidth-1:0] word_addr_t;
  typedef logic [PhysAddrLen-LineOffsetWidth-1:0] line_addr_t;

  typedef struct packed {
    logic [TagWidth-1:0] tag;
    logic                valid;
  } tag_t;

  typedef enum logic [3:0] {
    ExcNone             = 4'd0,
    ExcInstrAccessFault = 4'd1
  } exc_cause_e;

  typedef struct packed {
    logic [63:0] pc;
  } icache_req_t;

  typedef struct packed {
    word_t      instr;
    logic       exception;
    exc_cause_e ex_code;
  } icache_resp_t;

  typedef struct packed {
    word_t data;
    logic  denied;
  } mem_beat_t;

endpackage

`default_nettype wire

// File: icache_ram.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ram #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned Depth     = 64
) (
  input  logic                     clk_i,

  // Read port with data valid one cycle after rd_en_i
  input  logic                     rd_en_i,
  input  logic [$clog2(Depth)-1:0] rd_addr_i,
  output payload_t                 rd_data_o,

  // Write port
  input  logic                     wr_en_i,
  input  logic [$clog2(Depth)-1:0] wr_addr_i,
  input  payload_t                 wr_data_i
);

  payload_t mem_q [Depth];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_addr_i];
    end
  end

endmodule

`default_nettype wire

// File: icache_tag_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_lookup #(
  parameter int unsigned NumWays = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,

  // Lookup request and result one cycle later
  input  logic                               lookup_i,
  input  icache_pkg::set_t                   lookup_set_i,
  input  logic [icache_pkg::TagWidth-1:0]    lookup_tag_i,
  output logic [NumWays-1:0]                 hit_o,
  output logic [$clog2(NumWays)-1:0]         way_o,

  // Tag write from the refill unit
  input  logic                               tag_wr_i,
  input  logic [$clog2(NumWays)-1:0]         tag_wr_way_i,
  input  icache_pkg::set_t                   tag_wr_set_i,
  input  icache_pkg::tag_t                   tag_wr_data_i,

  // Set invalidation across all ways at once
  input  logic                               inval_i,
  input  icache_pkg::set_t                   inval_set_i,

  input  logic                               miss_i
);

  import icache_pkg::*;

  localparam int unsigned WayWidth = $clog2(NumWays);

  tag_t                rd_tag [NumWays];
  logic [TagWidth-1:0] lookup_tag_q;
  logic [WayWidth-1:0] fifo_q;

  // Tag under comparison, aligned with the RAM read data
  always_ff @(posedge clk_i) begin
    if (lookup_i) begin
      lookup_tag_q <= lookup_tag_i;
    end
  end

  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    logic wr_en;

    assign wr_en = inval_i || (tag_wr_i && tag_wr_way_i == WayWidth'(w));

    icache_ram #(
      .payload_t (tag_t),
      .Depth     (NumSets)
    ) ram_inst (
      .clk_i     (clk_i),
      .rd_en_i   (lookup_i),
      .rd_addr_i (lookup_set_i),
      .rd_data_o (rd_tag[w]),
      .wr_en_i   (wr_en),
      .wr_addr_i (inval_i ? inval_set_i : tag_wr_set_i),
      .wr_data_i (inval_i ? tag_t'('0) : tag_wr_data_i)
    );

    assign hit_o[w] = rd_tag[w].valid && rd_tag[w].tag == lookup_tag_q;
  end

  // Lowest hit way, then lowest empty way, then the FIFO victim
  always_comb begin
    way_o = fifo_q;
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (!rd_tag[i].valid) begin
        way_o = WayWidth'(i);
      end
    end
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (hit_o[i]) begin
        way_o = WayWidth'(i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fifo_q <= '0;
    end else if (miss_i) begin
      fifo_q <= fifo_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: icache_data_store.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data_store #(
  parameter int unsigned NumWays = 4
) (
  input  logic                            clk_i,

  // Lookup with one word per way one cycle later
  input  logic                            lookup_i,
  input  icache_pkg::word_addr_t          lookup_addr_i,
  output icache_pkg::word_t [NumWays-1:0] words_o,

  // Refill beat write
  input  logic                            wr_i,
  input  logic [$clog2(NumWays)-1:0]      wr_way_i,
  input  icache_pkg::word_addr_t          wr_addr_i,
  input  icache_pkg::word_t               wr_data_i
);

  import icache_pkg::*;

  localparam int unsigned WayWidth = $clog2(NumWays);
  localparam int unsigned Depth    = NumSets * WordsPerLine;

  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    logic wr_en;

    // Only the way being refilled takes the beat
    assign wr_en = wr_i && wr_way_i == WayWidth'(w);

    icache_ram #(
      .payload_t (word_t),
      .Depth     (Depth)
    ) ram_inst (
      .clk_i     (clk_i),
      .rd_en_i   (lookup_i),
      .rd_addr_i (lookup_addr_i),
      .rd_data_o (words_o[w]),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr_i),
      .wr_data_i (wr_data_i)
    );
  end

endmodule

`default_nettype wire

// File: icache_refill.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill #(
  parameter int unsigned NumWays = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // Refill command from the controller
  input  logic                       start_i,
  input  logic [$clog2(NumWays)-1:0] way_i,
  input  icache_pkg::line_addr_t     line_i,

  // Memory beats
  input  logic                       beat_valid_i,
  input  icache_pkg::mem_beat_t      beat_i,

  // Data RAM write
  output logic                       data_wr_o,
  output logic [$clog2(NumWays)-1:0] data_wr_way_o,
  output icache_pkg::word_addr_t     data_wr_addr_o,
  output icache_pkg::word_t          data_wr_data_o,

  // Tag RAM write
  output logic                       tag_wr_o,
  output logic [$clog2(NumWays)-1:0] tag_wr_way_o,
  output icache_pkg::set_t           tag_wr_set_o,
  output icache_pkg::tag_t           tag_wr_data_o,

  output logic                       done_o,
  output logic                       denied_o
);

  import icache_pkg::*;

  typedef enum logic [1:0] {
    RefillIdle,
    RefillProgress,
    RefillComplete
  } refill_state_e;

  refill_state_e                state_q, state_d;
  logic [WordOffsetWidth-1:0]   idx_q, idx_d;
  logic                         denied_q, denied_d;
  logic [$clog2(NumWays)-1:0]   way_q;
  line_addr_t                   line_q;

  // Target of the refill is held for the whole line
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      way_q  <= way_i;
      line_q <= line_i;
    end
  end

  assign data_wr_way_o  = way_q;
  assign data_wr_addr_o = {line_q[SetsWidth-1:0], idx_q};
  assign data_wr_data_o = beat_i.data;

  assign tag_wr_way_o       = way_q;
  assign tag_wr_set_o       = line_q[SetsWidth-1:0];
  assign tag_wr_data_o.tag  = line_q[$bits(line_addr_t)-1:SetsWidth];
  assign tag_wr_data_o.valid = 1'b1;

  assign denied_o = denied_q;

  always_comb begin
    state_d   = state_q;
    idx_d     = idx_q;
    denied_d  = denied_q;
    data_wr_o = 1'b0;
    tag_wr_o  = 1'b0;
    done_o    = 1'b0;

    unique case (state_q)
      RefillIdle: begin
        if (start_i) begin
          idx_d    = '0;
          denied_d = 1'b0;
          state_d  = RefillProgress;
        end
      end

      RefillProgress: begin
        if (beat_valid_i) begin
          data_wr_o = !beat_i.denied;
          denied_d  = denied_q || beat_i.denied;
          idx_d     = idx_q + 1'b1;
          // A denied beat anywhere in the line keeps the tag invalid
          if (&idx_q) begin
            tag_wr_o = !denied_d;
            state_d  = RefillComplete;
          end
        end
      end

      RefillComplete: begin
        done_o  = 1'b1;
        state_d = RefillIdle;
      end

      default: state_d = RefillIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= RefillIdle;
      idx_q    <= '0;
      denied_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      idx_q    <= idx_d;
      denied_q <= denied_d;
    end
  end

endmodule

`default_nettype wire

// File: icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
  parameter int unsigned NumWays = 4
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  // CPU side
  input  logic                            req_valid_i,
  input  icache_pkg::icache_req_t         req_i,
  output logic                            resp_valid_o,
  output icache_pkg::icache_resp_t        resp_o,
  input  logic                            flush_i,
  output logic                            flush_done_o,

  // Tag and data lookup
  output logic                            lookup_o,
  output icache_pkg::word_addr_t          lookup_addr_o,
  output logic [icache_pkg::TagWidth-1:0] lookup_tag_o,
  input  logic [NumWays-1:0]              hit_i,
  input  logic [$clog2(NumWays)-1:0]      way_i,
  input  icache_pkg::word_t [NumWays-1:0] words_i,
  output logic                            miss_o,

  // Invalidation sweep
  output logic                            inval_o,
  output icache_pkg::set_t                inval_set_o,

  // Refill unit
  output logic                            refill_start_o,
  output logic [$clog2(NumWays)-1:0]      refill_way_o,
  output icache_pkg::line_addr_t          refill_line_o,
  input  logic                            refill_done_i,
  input  logic                            refill_denied_i,

  // Memory request
  output logic                            mem_req_valid_o,
  output icache_pkg::line_addr_t          mem_req_addr_o
);

  import icache_pkg::*;

  localparam int unsigned TagLsb = SetsWidth + LineOffsetWidth;

  typedef enum logic [2:0] {
    StateSweep,
    StateIdle,
    StateLookup,
    StateFill,
    StateReplay,
    StateFault
  } state_e;

  state_e                     state_q, state_d;
  set_t                       sweep_q, sweep_d;
  logic                       flush_done_q;
  logic [PhysAddrLen-1:0]     pc_q;
  logic [$clog2(NumWays)-1:0] way_q;

  ////////////////////////////////////////
  // Request and victim latches
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (state_q == StateIdle && req_valid_i) begin
      pc_q <= req_i.pc[PhysAddrLen-1:0];
    end
    if (state_q == StateLookup && !(|hit_i)) begin
      way_q <= way_i;
    end
  end

  assign inval_set_o    = sweep_q;
  assign refill_way_o   = way_i;
  assign refill_line_o  = pc_q[PhysAddrLen-1:LineOffsetWidth];
  assign mem_req_addr_o = pc_q[PhysAddrLen-1:LineOffsetWidth];
  assign flush_done_o   = flush_done_q;

  ////////////////////////////////////////
  // Main FSM
  ////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    sweep_d         = sweep_q;
    lookup_o        = 1'b0;
    lookup_addr_o   = pc_q[TagLsb-1:ByteOffsetWidth];
    lookup_tag_o    = pc_q[PhysAddrLen-1:TagLsb];
    miss_o          = 1'b0;
    inval_o         = 1'b0;
    refill_start_o  = 1'b0;
    mem_req_valid_o = 1'b0;
    resp_valid_o    = 1'b0;
    resp_o.instr     = words_i[way_q];
    resp_o.exception = 1'b0;
    resp_o.ex_code   = ExcNone;

    unique case (state_q)
      // Clear one set per cycle across all ways
      StateSweep: begin
        inval_o = 1'b1;
        sweep_d = sweep_q + 1'b1;
        if (&sweep_q) begin
          state_d = StateIdle;
        end
      end

      StateIdle: begin
        if (flush_i) begin
          state_d = StateSweep;
        end else if (req_valid_i) begin
          if (|req_i.pc[63:PhysAddrLen]) begin
            state_d = StateFault;
          end else begin
            lookup_o      = 1'b1;
            lookup_addr_o = req_i.pc[TagLsb-1:ByteOffsetWidth];
            lookup_tag_o  = req_i.pc[PhysAddrLen-1:TagLsb];
            state_d       = StateLookup;
          end
        end
      end

      StateLookup: begin
        if (|hit_i) begin
          resp_valid_o = 1'b1;
          resp_o.instr = words_i[way_i];
          state_d      = StateIdle;
        end else begin
          miss_o          = 1'b1;
          refill_start_o  = 1'b1;
          mem_req_valid_o = 1'b1;
          state_d         = StateFill;
        end
      end

      // Arrays belong to the refill unit here
      StateFill: begin
        if (refill_done_i) begin
          if (refill_denied_i) begin
            state_d = StateFault;
          end else begin
            lookup_o = 1'b1;
            state_d  = StateReplay;
          end
        end
      end

      // The refilled way holds the line, so no hit check is needed
      StateReplay: begin
        resp_valid_o = 1'b1;
        state_d      = StateIdle;
      end

      StateFault: begin
        resp_valid_o     = 1'b1;
        resp_o.instr     = '0;
        resp_o.exception = 1'b1;
        resp_o.ex_code   = ExcInstrAccessFault;
        state_d          = StateIdle;
      end

      default: state_d = StateSweep;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= StateSweep;
      sweep_q      <= '0;
      flush_done_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      sweep_q      <= sweep_d;
      flush_done_q <= state_q == StateSweep && &sweep_q;
    end
  end

endmodule

`default_nettype wire

// File: icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
  parameter int unsigned NumWays = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // CPU side
  input  logic                     req_valid_i,
  input  icache_pkg::icache_req_t  req_i,
  output logic                     resp_valid_o,
  output icache_pkg::icache_resp_t resp_o,
  input  logic                     flush_i,
  output logic                     flush_done_o,

  // Memory side
  output logic                     mem_req_valid_o,
  output icache_pkg::line_addr_t   mem_req_addr_o,
  input  logic                     mem_beat_valid_i,
  input  icache_pkg::mem_beat_t    mem_beat_i
);

  import icache_pkg::*;

  localparam int unsigned WayWidth = $clog2(NumWays);

  // Lookup path
  logic                      lookup;
  word_addr_t                lookup_addr;
  logic [TagWidth-1:0]       lookup_tag;
  logic [NumWays-1:0]        hit;
  logic [WayWidth-1:0]       hit_way;
  word_t [NumWays-1:0]       words;
  logic                      miss;

  // Sweep
  logic                      inval;
  set_t                      inval_set;

  // Refill path
  logic                      refill_start;
  logic [WayWidth-1:0]       refill_way;
  line_addr_t                refill_line;
  logic                      refill_done;
  logic                      refill_denied;
  logic                      data_wr;
  logic [WayWidth-1:0]       data_wr_way;
  word_addr_t                data_wr_addr;
  word_t                     data_wr_data;
  logic                      tag_wr;
  logic [WayWidth-1:0]       tag_wr_way;
  set_t                      tag_wr_set;
  tag_t                      tag_wr_data;

  icache_ctrl #(
    .NumWays (NumWays)
  ) ctrl_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .resp_valid_o    (resp_valid_o),
    .resp_o          (resp_o),
    .flush_i         (flush_i),
    .flush_done_o    (flush_done_o),
    .lookup_o        (lookup),
    .lookup_addr_o   (lookup_addr),
    .lookup_tag_o    (lookup_tag),
    .hit_i           (hit),
    .way_i           (hit_way),
    .words_i         (words),
    .miss_o          (miss),
    .inval_o         (inval),
    .inval_set_o     (inval_set),
    .refill_start_o  (refill_start),
    .refill_way_o    (refill_way),
    .refill_line_o   (refill_line),
    .refill_done_i   (refill_done),
    .refill_denied_i (refill_denied),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_addr_o  (mem_req_addr_o)
  );

  icache_tag_lookup #(
    .NumWays (NumWays)
  ) tag_lookup_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_i      (lookup),
    .lookup_set_i  (lookup_addr[WordOffsetWidth+:SetsWidth]),
    .lookup_tag_i  (lookup_tag),
    .hit_o         (hit),
    .way_o         (hit_way),
    .tag_wr_i      (tag_wr),
    .tag_wr_way_i  (tag_wr_way),
    .tag_wr_set_i  (tag_wr_set),
    .tag_wr_data_i (tag_wr_data),
    .inval_i       (inval),
    .inval_set_i   (inval_set),
    .miss_i        (miss)
  );

  icache_data_store #(
    .NumWays (NumWays)
  ) data_store_inst (
    .clk_i         (clk_i),
    .lookup_i      (lookup),
    .lookup_addr_i (lookup_addr),
    .words_o       (words),
    .wr_i          (data_wr),
    .wr_way_i      (data_wr_way),
    .wr_addr_i     (data_wr_addr),
    .wr_data_i     (data_wr_data)
  );

  icache_refill #(
    .NumWays (NumWays)
  ) refill_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (refill_start),
    .way_i          (refill_way),
    .line_i         (refill_line),
    .beat_valid_i   (mem_beat_valid_i),
    .beat_i         (mem_beat_i),
    .data_wr_o      (data_wr),
    .data_wr_way_o  (data_wr_way),
    .data_wr_addr_o (data_wr_addr),
    .data_wr_data_o (data_wr_data),
    .tag_wr_o       (tag_wr),
    .tag_wr_way_o   (tag_wr_way),
    .tag_wr_set_o   (tag_wr_set),
    .tag_wr_data_o  (tag_wr_data),
    .done_o         (refill_done),
    .denied_o       (refill_denied)
  );

endmodule

`default_nettype wire

// File: icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

  import icache_pkg::*;

  localparam int          ClkPeriod    = 40;
  localparam int          NumWays      = 4;
  localparam logic [31:0] Seed         = 32'd60;
  localparam int          MaxMemDelay  = 5;
  localparam int          MaxBeatGap   = 3;
  localparam int          NumFirst     = 8;
  localparam int          NumRandom    = 48;
  localparam int          RandomLines  = 12;
  localparam int          NumSameSet   = 12;
  localparam int          SameSetLines = 5;
  localparam int          NumFault     = 4;
  localparam int          NumRefetch   = NumFirst + RandomLines + SameSetLines;
  localparam int          NumRequests  = 2 * NumFirst + NumRandom + NumSameSet + NumFault +
                                         NumRefetch;
  // Worst case for one miss covers the request, memory delay, gapped beats and replay
  localparam int          RefillCycles = 8 + MaxMemDelay + WordsPerLine * (MaxBeatGap + 1);
  localparam int          SweepCycles  = NumSets + 4;
  localparam int          NumSweeps    = 2;
  localparam int          TimeoutCycles = NumRequests * RefillCycles + NumSweeps * SweepCycles +
                                          50;

  typedef enum logic [1:0] {
    KindHit,
    KindMiss,
    KindBadPc
  } kind_e;

  // One outstanding request with its predicted response
  typedef struct packed {
    logic [63:0]  pc;
    icache_resp_t resp;
    kind_e        kind;
    logic [31:0]  issue;
  } pending_t;

  logic         clk_i            = 1'b0;
  logic         rst_ni           = 1'b0;
  logic         req_valid_i      = 1'b0;
  icache_req_t  req_i            = '0;
  logic         resp_valid_o;
  icache_resp_t resp_o;
  logic         flush_i          = 1'b0;
  logic         flush_done_o;
  logic         mem_req_valid_o;
  line_addr_t   mem_req_addr_o;
  logic         mem_beat_valid_i = 1'b0;
  mem_beat_t    mem_beat_i       = '0;

  pending_t    pending_q  [$];
  line_addr_t  line_exp_q [$];
  line_addr_t  touched_q  [$];
  int unsigned cycle_cnt       = 0;
  int unsigned resp_count      = 0;
  int unsigned flush_count     = 0;
  int unsigned beat_cnt        = 0;
  int unsigned last_beat_cycle = 0;
  int unsigned flush_issue     = 0;
  logic        flush_pending   = 1'b0;
  logic [31:0] mem_rnd         = Seed;

  // Tag model of the cache
  logic [TagWidth-1:0]        tag_store [NumSets][NumWays];
  logic                       tag_valid [NumSets][NumWays];
  logic [$clog2(NumWays)-1:0] fifo_model = '0;

  int same_set_order [NumSameSet] = '{0, 1, 2, 3, 4, 0, 1, 2, 3, 4, 0, 4};

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  icache_top #(
    .NumWays (NumWays)
  ) icache_top_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_valid_i      (req_valid_i),
    .req_i            (req_i),
    .resp_valid_o     (resp_valid_o),
    .resp_o           (resp_o),
    .flush_i          (flush_i),
    .flush_done_o     (flush_done_o),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_beat_valid_i (mem_beat_valid_i),
    .mem_beat_i       (mem_beat_i)
  );

  ////////////////////////////////////////
  // Reference and error helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Instruction word at a byte address is a mix of its word address
  function automatic word_t ref_word(input logic [31:0] addr);
    logic [29:0] w;
    w = addr[31:2];
    return ({2'b00, w} * 32'h9E37_79B9) ^ {w[15:0], w[29:14]};
  endfunction

  // Bad pc and lines with bit 31 set both end in an access fault
  function automatic icache_resp_t ref_resp(input logic [63:0] pc);
    icache_resp_t r;
    if (|pc[63:PhysAddrLen] || pc[PhysAddrLen-1]) begin
      r.instr     = '0;
      r.exception = 1'b1;
      r.ex_code   = ExcInstrAccessFault;
    end else begin
      r.instr     = ref_word(pc[PhysAddrLen-1:0]);
      r.exception = 1'b0;
      r.ex_code   = ExcNone;
    end
    return r;
  endfunction

  task automatic stop_failed();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic value_error(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    stop_failed();
  endtask

  task automatic plain_error(input string msg);
    $display("%s", msg);
    stop_failed();
  endtask

  // Instruction only matters when no exception is expected
  task automatic compare_resp(input icache_resp_t got, input icache_resp_t exp,
                              input logic [63:0] pc);
    if (got.exception !== exp.exception || got.ex_code !== exp.ex_code ||
        (!exp.exception && got.instr !== exp.instr)) begin
      value_error($sformatf("pc %h gave instr %h exc %0b code %0d, expected %h %0b %0d",
                            pc, got.instr, got.exception, got.ex_code,
                            exp.instr, exp.exception, exp.ex_code));
    end
  endtask

  task automatic compare_line(input line_addr_t got, input line_addr_t exp);
    if (got !== exp) begin
      value_error($sformatf("memory request for line %h, expected line %h", got, exp));
    end
  endtask

  task automatic compare_latency(input int got, input int exp, input string what);
    if (got != exp) begin
      value_error($sformatf("%s came after %0d cycles, expected %0d", what, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // Tag model
  ////////////////////////////////////////

  function automatic logic tags_hit(input line_addr_t line);
    set_t set;
    logic hit;
    set = line[SetsWidth-1:0];
    hit = 1'b0;
    for (int w = 0; w < NumWays; w++) begin
      if (tag_valid[set][w] && tag_store[set][w] == line[$bits(line_addr_t)-1:SetsWidth]) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Victim is the lowest empty way or the FIFO counter, which moves on every miss
  task automatic fill_victim(input line_addr_t line);
    set_t set;
    int   way;
    set = line[SetsWidth-1:0];
    way = -1;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!tag_valid[set][w]) begin
        way = w;
      end
    end
    if (way < 0) begin
      way = int'(fifo_model);
    end
    fifo_model = fifo_model + 1'b1;
    // Denied lines never get a valid tag
    if (!line[$bits(line_addr_t)-1]) begin
      tag_valid[set][way] = 1'b1;
      tag_store[set][way] = line[$bits(line_addr_t)-1:SetsWidth];
    end
  endtask

  task automatic clear_tags();
    for (int s = 0; s < NumSets; s++) begin
      for (int w = 0; w < NumWays; w++) begin
        tag_valid[s][w] = 1'b0;
        tag_store[s][w] = '0;
      end
    end
  endtask

  function automatic logic line_touched(input line_addr_t line);
    foreach (touched_q[i]) begin
      if (touched_q[i] == line) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  ////////////////////////////////////////
  // CPU side stimulus
  ////////////////////////////////////////

  task automatic access(input logic [63:0] pc);
    pending_t    p;
    line_addr_t  line;
    int unsigned seen;
    line   = pc[PhysAddrLen-1:LineOffsetWidth];
    p.pc   = pc;
    p.resp = ref_resp(pc);
    if (|pc[63:PhysAddrLen]) begin
      p.kind = KindBadPc;
    end else if (tags_hit(line)) begin
      p.kind = KindHit;
    end else begin
      p.kind = KindMiss;
      line_exp_q.push_back(line);
      fill_victim(line);
      if (!line[$bits(line_addr_t)-1] && !line_touched(line)) begin
        touched_q.push_back(line);
      end
    end
    @(negedge clk_i);
    // Cycle in which the DUT samples the request
    p.issue = cycle_cnt + 1;
    pending_q.push_back(p);
    seen        = resp_count;
    req_valid_i = 1'b1;
    req_i.pc    = pc;
    @(negedge clk_i);
    req_valid_i = 1'b0;
    req_i       = '0;
    while (resp_count == seen) begin
      @(negedge clk_i);
    end
    if (line_exp_q.size() != 0) begin
      plain_error($sformatf("No memory request was made for line %h of pc %h", line, pc));
    end
  endtask

  task automatic flush_cache();
    int unsigned seen;
    @(negedge clk_i);
    seen          = flush_count;
    flush_issue   = cycle_cnt + 1;
    flush_pending = 1'b1;
    flush_i       = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    while (flush_count == seen) begin
      @(negedge clk_i);
    end
    clear_tags();
  endtask

  initial begin : stimulus
    logic [31:0] rnd;
    logic [63:0] pc;
    line_addr_t  refetch_q [$];
    rnd = Seed ^ 32'h9E37_79B9;
    clear_tags();
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    // No request before the reset sweep is over
    while (flush_count == 0) begin
      @(negedge clk_i);
    end

    // First access to each line, then repeats that must hit
    for (int i = 0; i < NumFirst; i++) begin
      access({32'h0, 32'h0000_1000 + 32'(i) * 64 + 32'((i * 5) % 16) * 4});
    end
    for (int i = 0; i < NumFirst; i++) begin
      access({32'h0, 32'h0000_1000 + 32'(i) * 64 + 32'((i * 7 + 3) % 16) * 4});
    end

    for (int i = 0; i < NumRandom; i++) begin
      rnd = xorshift32(rnd);
      pc  = {32'h0, 32'h0004_0000 + (rnd % 32'(RandomLines)) * 64 + ((rnd >> 8) % 16) * 4};
      access(pc);
    end

    // Five tags in set 40 force FIFO evictions
    for (int i = 0; i < NumSameSet; i++) begin
      access({32'h0, 32'h0030_0000 + 32'(same_set_order[i]) * 32'h1000 + 32'd40 * 64 +
              32'(i % 16) * 4});
    end

    access(64'h0000_0001_0000_1000);
    access(64'h8000_0000_0000_0040);
    access(64'h0000_0000_8000_0104);
    access(64'h0000_0000_8000_0104);

    flush_cache();
    refetch_q = touched_q;
    foreach (refetch_q[i]) begin
      access({32'h0, refetch_q[i], 6'h0});
    end

    repeat (4) @(negedge clk_i);
    if (pending_q.size() != 0 || line_exp_q.size() != 0) begin
      plain_error("Responses or memory requests were still expected at the end of the run");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////

  always begin : memory_model
    line_addr_t  line;
    int unsigned delay;
    int unsigned gap;
    @(posedge clk_i);
    if (rst_ni && mem_req_valid_o) begin
      line    = mem_req_addr_o;
      mem_rnd = xorshift32(mem_rnd);
      delay   = mem_rnd % (MaxMemDelay + 1);
      @(negedge clk_i);
      repeat (delay) @(negedge clk_i);
      for (int b = 0; b < WordsPerLine; b++) begin
        mem_beat_valid_i  = 1'b1;
        mem_beat_i.data   = ref_word({line, WordOffsetWidth'(b), 2'b00});
        mem_beat_i.denied = line[$bits(line_addr_t)-1];
        @(negedge clk_i);
        mem_beat_valid_i = 1'b0;
        mem_beat_i       = '0;
        if (b < WordsPerLine - 1) begin
          mem_rnd = xorshift32(mem_rnd);
          gap     = mem_rnd % (MaxBeatGap + 1);
          repeat (gap) @(negedge clk_i);
        end
      end
    end
  end

  ////////////////////////////////////////
  // Response and request checks
  ////////////////////////////////////////

  always @(posedge clk_i) begin : monitor
    pending_t p;
    cycle_cnt = cycle_cnt + 1;
    if (!rst_ni) begin
      if (resp_valid_o || mem_req_valid_o || flush_done_o) begin
        plain_error("A DUT strobe was high during reset");
      end
    end else begin
      if (mem_beat_valid_i) begin
        beat_cnt = beat_cnt + 1;
        if (beat_cnt == WordsPerLine) begin
          last_beat_cycle = cycle_cnt;
        end
      end
      if (mem_req_valid_o) begin
        if (line_exp_q.size() == 0 || pending_q.size() == 0) begin
          plain_error($sformatf("Unexpected memory request for line %h", mem_req_addr_o));
        end
        compare_line(mem_req_addr_o, line_exp_q.pop_front());
        compare_latency(int'(cycle_cnt - pending_q[0].issue), 1, "memory request");
        beat_cnt = 0;
      end
      if (resp_valid_o) begin
        if (pending_q.size() == 0) begin
          plain_error("The DUT gave a response with no request outstanding");
        end
        p = pending_q.pop_front();
        compare_resp(resp_o, p.resp, p.pc);
        if (p.kind == KindMiss) begin
          compare_latency(int'(cycle_cnt - last_beat_cycle), 2, "response after last beat");
        end else begin
          compare_latency(int'(cycle_cnt - p.issue), 1, "response");
        end
        resp_count = resp_count + 1;
      end
      if (flush_done_o) begin
        if (flush_pending) begin
          compare_latency(int'(cycle_cnt - flush_issue), NumSets + 1, "flush_done_o");
          flush_pending = 1'b0;
        end else if (flush_count != 0) begin
          plain_error("flush_done_o pulsed with no flush outstanding");
        end
        flush_count = flush_count + 1;
      end
    end
  end

  initial begin : watchdog
    #(TimeoutCycles * ClkPeriod);
    plain_error($sformatf("Timeout: the run did not end within %0d cycles", TimeoutCycles));
  end

endmodule

`default_nettype wire

// File: sim.f
icache_pkg.sv
icache_ram.sv
icache_tag_lookup.sv
icache_data_store.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
icache_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module icache_tb -o icache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/icache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if ! grep -q "Test OK" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
exit 0
